// File: dv/tb_checker.sv
// ====================
// Checker for the control-input front end
// Reference state follows rising edges, compares on falling edges
// Player checks pause while DB15 frames settle
// ====================
module tb_checker (
	input  logic                   clk_53p6,
	input  logic                   reset,
	input  logic                   check_en,
	input  logic                   check_players,
	// DUT inputs and adapter model words
	input  logic [1:0]             snac_sel,
	input  ctrl_pkg::usb_joy_t     joystick_0,
	input  ctrl_pkg::usb_joy_t     joystick_1,
	input  ctrl_pkg::db15_word_t   db15_w1,
	input  ctrl_pkg::db15_word_t   db15_w2,
	input  logic                   ioctl_wr,
	input  ctrl_pkg::ioctl_index_t ioctl_index,
	input  ctrl_pkg::ioctl_addr_t  ioctl_addr,
	input  ctrl_pkg::dip_t         ioctl_dout,
	input  ctrl_pkg::analog_t      analog_l,
	input  ctrl_pkg::analog_t      analog_r,
	// DUT outputs
	input  logic                   joy_clk,
	input  logic                   joy_load,
	input  logic                   pause,
	input  ctrl_pkg::player_word_t player1,
	input  ctrl_pkg::player_word_t player2,
	input  ctrl_pkg::dip_t         dsw1,
	input  ctrl_pkg::dip_t         dsw2,
	input  ctrl_pkg::game_id_t     game,
	input  ctrl_pkg::menu_mask_t   menu_mask,
	input  ctrl_pkg::trackball_t   trackball1,
	input  ctrl_pkg::trackball_t   trackball2,
	output int                     errors
);

	int err_cnt = 0;

	// Control inputs as seen by the DUT at the last rising edge
	logic in_reset;
	logic en_q;
	logic players_q;

	logic [1:0]           en_ref;
	logic [16:0]          ref1;
	logic [16:0]          ref2;
	ctrl_pkg::dip_t       exp_dsw1;
	ctrl_pkg::dip_t       exp_dsw2;
	ctrl_pkg::game_id_t   exp_game;
	ctrl_pkg::menu_mask_t exp_mask;
	logic [16:0]          exp_p1;
	logic [16:0]          exp_p2;
	ctrl_pkg::trackball_t got_tb1;
	ctrl_pkg::trackball_t got_tb2;
	ctrl_pkg::trackball_t exp_tb1;
	ctrl_pkg::trackball_t exp_tb2;

	assign errors = err_cnt;

	// ====================
	// Reference rules
	// ====================

	// Returns {pause, player word}
	function automatic logic [16:0] player_ref(input logic en, input ctrl_pkg::usb_joy_t usb,
			input ctrl_pkg::db15_word_t db);
		ctrl_pkg::player_word_t w;
		logic p;
		w = 16'hFFFF;
		if (en) begin
			w[13] = db[3];
			w[12] = db[2];
			w[11] = db[0];
			w[10] = db[1];
			// Select+B
			w[9] = !(db[5] == 1'b0 && db[11] == 1'b0);
			w[3] = db[6];
			w[2] = db[5];
			w[1] = db[10];
			w[0] = db[11];
			// Select+A
			p = (db[4] == 1'b0 && db[11] == 1'b0);
		end else begin
			w[13] = !usb[3];
			w[12] = !usb[2];
			w[11] = !usb[0];
			w[10] = !usb[1];
			w[9] = !usb[8];
			w[3] = !usb[5];
			w[2] = !usb[4];
			w[1] = !usb[6];
			w[0] = !usb[7];
			p = usb[9];
		end
		return {p, w};
	endfunction

	function automatic ctrl_pkg::menu_mask_t mask_ref(input ctrl_pkg::game_id_t g);
		ctrl_pkg::menu_mask_t m;
		m = ctrl_pkg::MASK_DEFAULT;
		if (g == ctrl_pkg::GAME_ATHENA)
			m[0] = 1'b0;
		else if (g == ctrl_pkg::GAME_COUNTRY_CLUB)
			m[1] = 1'b1;
		return m;
	endfunction

	function automatic ctrl_pkg::trackball_t trackball_ref(input ctrl_pkg::analog_t a);
		logic [7:0] y;
		logic [7:0] x;
		// Each axis keeps its top 7 bits, X inverted
		y = a[15:8] >> 1;
		x = ~a[7:0];
		x = x >> 1;
		return {y, x};
	endfunction

	// DB15 off for the trackball game
	always_comb begin
		en_ref = snac_sel;
		if (exp_game == ctrl_pkg::GAME_COUNTRY_CLUB)
			en_ref = 2'b00;
	end

	assign ref1 = player_ref(en_ref[0], joystick_0, db15_w1);
	assign ref2 = player_ref(en_ref[1], joystick_1, db15_w2);

	// ====================
	// Reference state
	// ====================
	always @(posedge clk_53p6) begin
		in_reset  <= reset;
		en_q      <= check_en;
		players_q <= check_players;
		got_tb1   <= trackball1;
		got_tb2   <= trackball2;
		exp_tb1   <= trackball_ref(analog_l);
		exp_tb2   <= trackball_ref(analog_r);
		if (reset) begin
			exp_dsw1 <= 8'hFF;
			exp_dsw2 <= 8'hFF;
			exp_game <= 8'h00;
			exp_mask <= ctrl_pkg::MASK_DEFAULT;
			exp_p1   <= 17'h0FFFF;
			exp_p2   <= 17'h0FFFF;
		end else begin
			if (ioctl_wr && ioctl_index == ctrl_pkg::IDX_DIP && ioctl_addr == 25'd0)
				exp_dsw1 <= ioctl_dout;
			if (ioctl_wr && ioctl_index == ctrl_pkg::IDX_DIP && ioctl_addr == 25'd1)
				exp_dsw2 <= ioctl_dout;
			if (ioctl_wr && ioctl_index == ctrl_pkg::IDX_GAME && ioctl_addr == 25'd0)
				exp_game <= ioctl_dout;
			// Mask follows the registered game, one more cycle
			exp_mask <= mask_ref(exp_game);
			exp_p1   <= ref1;
			exp_p2   <= ref2;
		end
	end

	// ====================
	// Comparison
	// ====================
	task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	always @(negedge clk_53p6) begin
		if (en_q) begin
			if (in_reset) begin
				compare("joy_clk", 16'(joy_clk), 16'h0000);
				compare("joy_load", 16'(joy_load), 16'h0000);
			end
			compare("dsw1", 16'(dsw1), 16'(exp_dsw1));
			compare("dsw2", 16'(dsw2), 16'(exp_dsw2));
			compare("game", 16'(game), 16'(exp_game));
			compare("menu_mask", menu_mask, exp_mask);
			compare("trackball1", got_tb1, exp_tb1);
			compare("trackball2", got_tb2, exp_tb2);
			if (players_q) begin
				compare("player1", player1, exp_p1[15:0]);
				compare("player2", player2, exp_p2[15:0]);
				compare("pause", 16'(pause), 16'(exp_p1[16] | exp_p2[16]));
			end
		end
	end

endmodule

// File: dv/tb_top.sv
// ====================
// Testbench for the control-input front end
// DB15 adapter is a behavioural shift register model
// Frame waits allow about one and a half DB15 frames
// ====================
module tb_top;

	// One frame is 8 load cycles, 256 shift cycles and DONE
	localparam int FRAME_TIMEOUT = 400;
	// Select+B and Select+A held, active low
	localparam ctrl_pkg::db15_word_t SELECT_B = 16'hF7DF;
	localparam ctrl_pkg::db15_word_t SELECT_A = 16'hF7EF;

	logic clk_53p6 = 1'b0;
	logic reset;
	logic joy_data;
	logic joy_clk;
	logic joy_load;
	logic ioctl_wr;
	ctrl_pkg::ioctl_index_t ioctl_index;
	ctrl_pkg::ioctl_addr_t  ioctl_addr;
	ctrl_pkg::dip_t         ioctl_dout;
	logic [1:0]             snac_sel;
	ctrl_pkg::usb_joy_t     joystick_0;
	ctrl_pkg::usb_joy_t     joystick_1;
	ctrl_pkg::analog_t      analog_l;
	ctrl_pkg::analog_t      analog_r;
	ctrl_pkg::player_word_t player1;
	ctrl_pkg::player_word_t player2;
	logic                   pause;
	ctrl_pkg::dip_t         dsw1;
	ctrl_pkg::dip_t         dsw2;
	ctrl_pkg::game_id_t     game;
	ctrl_pkg::menu_mask_t   menu_mask;
	ctrl_pkg::trackball_t   trackball1;
	ctrl_pkg::trackball_t   trackball2;

	// Checker control and adapter words
	logic check_en;
	logic check_players;
	ctrl_pkg::db15_word_t db15_w1;
	ctrl_pkg::db15_word_t db15_w2;

	int errors;
	int timeouts;
	int test_start;
	int iter;
	logic [31:0] seed;
	logic [15:0] rnd;

	ctrl_top UUT (.*);
	tb_checker chk (.*);

	always #10 clk_53p6 = ~clk_53p6;

	// ====================
	// DB15 adapter model
	// ====================
	logic [31:0] adapter_sreg = '1;
	logic        joy_clk_q = 1'b0;

	// Parallel load while joy_load is high, shift after each joy_clk fall
	always @(posedge clk_53p6) begin
		joy_clk_q <= joy_clk;
		if (joy_load)
			adapter_sreg <= {db15_w1, db15_w2};
		else if (joy_clk_q && !joy_clk)
			adapter_sreg <= {adapter_sreg[30:0], 1'b1};
	end

	assign joy_data = adapter_sreg[31];

	// ====================
	// Helpers
	// ====================
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic next_rand(output logic [15:0] value);
		seed = lcg_next(seed);
		value = seed[31:16];
	endtask

	task automatic wait_load(input logic level);
		int count;
		count = 0;
		while (joy_load !== level && count < FRAME_TIMEOUT) begin
			@(negedge clk_53p6);
			count++;
		end
		if (joy_load !== level) begin
			timeouts++;
			$display("Timeout: joy_load did not reach %0d within %0d cycles",
				level, FRAME_TIMEOUT);
		end
	endtask

	// Single-cycle write strobe, returns two cycles after the write
	task automatic download(input ctrl_pkg::ioctl_index_t index,
			input ctrl_pkg::ioctl_addr_t addr, input ctrl_pkg::dip_t data);
		ioctl_index = index;
		ioctl_addr  = addr;
		ioctl_dout  = data;
		ioctl_wr    = 1'b1;
		@(negedge clk_53p6);
		ioctl_wr = 1'b0;
		@(negedge clk_53p6);
	endtask

	// Let the last falling edge compare land before counting
	task automatic finish_test(input string name);
		@(posedge clk_53p6);
		$display("Test %s done, %0d errors", name, errors - test_start);
		test_start = errors;
		@(negedge clk_53p6);
	endtask

	// ====================
	// Stimulus
	// ====================
	initial begin
		seed          = 32'h21e7;
		reset         = 1'b1;
		ioctl_wr      = 1'b0;
		ioctl_index   = 8'h00;
		ioctl_addr    = 25'd0;
		ioctl_dout    = 8'h00;
		snac_sel      = 2'b00;
		joystick_0    = 16'h0000;
		joystick_1    = 16'h0000;
		analog_l      = 16'h0000;
		analog_r      = 16'h0000;
		db15_w1       = 16'hFFFF;
		db15_w2       = 16'hFFFF;
		check_en      = 1'b0;
		check_players = 1'b1;
		timeouts      = 0;
		test_start    = 0;

		// Four reset cycles, checks start once registers hold reset values
		repeat (2) @(negedge clk_53p6);
		check_en = 1'b1;
		repeat (2) @(negedge clk_53p6);
		reset = 1'b0;
		finish_test("reset");

		// USB path, DB15 disabled
		repeat (200) begin
			next_rand(joystick_0);
			next_rand(joystick_1);
			@(negedge clk_53p6);
		end
		finish_test("usb_path");

		// DB15 path, random frames then button combinations
		snac_sel = 2'b11;
		for (iter = 0; iter < 6; iter++) begin
			check_players = 1'b0;
			if (iter == 4) begin
				db15_w1 = SELECT_B;
				db15_w2 = SELECT_A;
			end else if (iter == 5) begin
				db15_w1 = SELECT_A;
				db15_w2 = SELECT_B;
			end else begin
				next_rand(db15_w1);
				next_rand(db15_w2);
			end
			// Frame with the new words starts, ends, next one starts
			wait_load(1'b0);
			wait_load(1'b1);
			wait_load(1'b0);
			wait_load(1'b1);
			repeat (2) @(negedge clk_53p6);
			check_players = 1'b1;
			repeat (4) @(negedge clk_53p6);
		end
		finish_test("db15_path");

		// Download capture, DIP bytes beyond 1 are dropped
		download(ctrl_pkg::IDX_DIP, 25'd0, 8'h5A);
		download(ctrl_pkg::IDX_DIP, 25'd1, 8'hC3);
		for (iter = 2; iter < 8; iter++) begin
			next_rand(rnd);
			download(ctrl_pkg::IDX_DIP, ctrl_pkg::ioctl_addr_t'(iter), rnd[7:0]);
		end
		download(ctrl_pkg::IDX_GAME, 25'd0, 8'h33);
		finish_test("download");

		// Game rules, trackball game falls back to USB
		download(ctrl_pkg::IDX_GAME, 25'd0, ctrl_pkg::GAME_COUNTRY_CLUB);
		repeat (20) begin
			next_rand(joystick_0);
			next_rand(joystick_1);
			@(negedge clk_53p6);
		end
		download(ctrl_pkg::IDX_GAME, 25'd0, ctrl_pkg::GAME_ATHENA);
		download(ctrl_pkg::IDX_GAME, 25'd0, 8'h05);
		finish_test("game_rules");

		// Trackball words
		repeat (50) begin
			next_rand(analog_l);
			next_rand(analog_r);
			@(negedge clk_53p6);
		end
		finish_test("trackball");

		$display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: logic/ctrl_pkg.sv
// ====================
// Shared types and constants for the control-input front end
// All words are 16 bits; cabinet and DB15 words are active low
// Game IDs and download indices match the MRA download layout
// ====================
package ctrl_pkg;

	// ====================
	// Data words
	// ====================

	// Cabinet player word, active low
	typedef logic [15:0] player_word_t;
	// USB joystick bits, active high
	typedef logic [15:0] usb_joy_t;
	// DB15 adapter word, active low
	typedef logic [15:0] db15_word_t;
	// Analog stick, Y in [15:8], X in [7:0]
	typedef logic [15:0] analog_t;
	typedef logic [15:0] trackball_t;

	// Download and configuration
	typedef logic [7:0]  dip_t;
	typedef logic [7:0]  game_id_t;
	typedef logic [15:0] menu_mask_t;
	typedef logic [24:0] ioctl_addr_t;
	typedef logic [7:0]  ioctl_index_t;

	// ====================
	// DB15 serial frame
	// ====================

	// System clocks per half period of joy_clk
	localparam int unsigned DB15_HALF_CYCLES = 4;
	localparam int unsigned DB15_FRAME_BITS = 32;

	// Counter covers the load pulse, which is two half periods
	typedef logic [$clog2(2 * DB15_HALF_CYCLES)-1:0] db15_half_cnt_t;
	// Counts joy_clk pulses within one frame
	typedef logic [$clog2(DB15_FRAME_BITS)-1:0] db15_bit_cnt_t;
	// Both players back to back, player 1 first
	typedef logic [DB15_FRAME_BITS-1:0] db15_frame_t;

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		SHIFT,
		DONE
	} db15_state_t;

	// ====================
	// Download and game IDs
	// ====================
	localparam ioctl_index_t IDX_GAME = 8'd1;
	localparam ioctl_index_t IDX_DIP = 8'd254;

	localparam game_id_t GAME_ATHENA = 8'h02;
	// Trackball game, DB15 not supported
	localparam game_id_t GAME_COUNTRY_CLUB = 8'h14;

	// OSD mask with DB15 menu enabled
	localparam menu_mask_t MASK_DEFAULT = 16'h00FD;

	// Released and default values
	localparam player_word_t PLAYER_RELEASED = 16'hFFFF;
	localparam db15_word_t DB15_RELEASED = 16'hFFFF;
	localparam dip_t DIP_DEFAULT = 8'hFF;

endpackage

// File: logic/ctrl_top.sv
// ====================
// Control-input front end of the arcade wrapper, clk_53p6 domain
// USB and analog inputs are assumed synchronous to clk_53p6
// Trackball words are a direct stick mapping, no accumulation
// ====================
module ctrl_top (
	input  logic                   clk_53p6,
	input  logic                   reset,
	// DB15 adapter
	input  logic                   joy_data,
	output logic                   joy_clk,
	output logic                   joy_load,
	// ROM download
	input  logic                   ioctl_wr,
	input  ctrl_pkg::ioctl_index_t ioctl_index,
	input  ctrl_pkg::ioctl_addr_t  ioctl_addr,
	input  ctrl_pkg::dip_t         ioctl_dout,
	// OSD DB15 device select, one bit per player
	input  logic [1:0]             snac_sel,
	// USB controls
	input  ctrl_pkg::usb_joy_t     joystick_0,
	input  ctrl_pkg::usb_joy_t     joystick_1,
	input  ctrl_pkg::analog_t      analog_l,
	input  ctrl_pkg::analog_t      analog_r,
	// Core side
	output ctrl_pkg::player_word_t player1,
	output ctrl_pkg::player_word_t player2,
	output logic                   pause,
	output ctrl_pkg::dip_t         dsw1,
	output ctrl_pkg::dip_t         dsw2,
	output ctrl_pkg::game_id_t     game,
	output ctrl_pkg::menu_mask_t   menu_mask,
	output ctrl_pkg::trackball_t   trackball1,
	output ctrl_pkg::trackball_t   trackball2
);

	ctrl_pkg::db15_word_t db15_p1;
	ctrl_pkg::db15_word_t db15_p2;
	logic [1:0]           db15_en;
	logic                 pause1;
	logic                 pause2;

	// ====================
	// DB15 adapter
	// ====================

	// Words hold between frames, so the frame strobe is left open
	db15_reader u_db15_reader (
		.clk_53p6   (clk_53p6),
		.reset      (reset),
		.joy_data   (joy_data),
		.joy_clk    (joy_clk),
		.joy_load   (joy_load),
		.db15_p1    (db15_p1),
		.db15_p2    (db15_p2),
		.db15_valid ()
	);

	// ====================
	// Download configuration
	// ====================
	game_config u_game_config (
		.clk_53p6    (clk_53p6),
		.reset       (reset),
		.ioctl_wr    (ioctl_wr),
		.ioctl_index (ioctl_index),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.snac_sel    (snac_sel),
		.dsw1        (dsw1),
		.dsw2        (dsw2),
		.game        (game),
		.menu_mask   (menu_mask),
		.db15_en     (db15_en)
	);

	// ====================
	// Player mapping
	// ====================
	player_mapper u_player1 (
		.clk_53p6 (clk_53p6),
		.reset    (reset),
		.db15_en  (db15_en[0]),
		.usb      (joystick_0),
		.db15     (db15_p1),
		.player   (player1),
		.pause    (pause1)
	);

	player_mapper u_player2 (
		.clk_53p6 (clk_53p6),
		.reset    (reset),
		.db15_en  (db15_en[1]),
		.usb      (joystick_1),
		.db15     (db15_p2),
		.player   (player2),
		.pause    (pause2)
	);

	// Either player may pause
	assign pause = pause1 | pause2;

	// Trackball from sticks, top 7 bits of each axis
	// X is inverted to match the cabinet direction
	assign trackball1 = {1'b0, analog_l[15:9], 1'b0, ~analog_l[7:1]};
	assign trackball2 = {1'b0, analog_r[15:9], 1'b0, ~analog_r[7:1]};

endmodule

// File: logic/db15_reader.sv
// ====================
// Serial reader for a two-player DB15 adapter (shift register type)
// joy_data must be stable while joy_clk is high
// Frames repeat back to back, words update once per frame
// ====================
module db15_reader (
	input  logic                 clk_53p6,
	input  logic                 reset,
	input  logic                 joy_data,
	output logic                 joy_clk,
	output logic                 joy_load,
	output ctrl_pkg::db15_word_t db15_p1,
	output ctrl_pkg::db15_word_t db15_p2,
	output logic                 db15_valid
);

	ctrl_pkg::db15_state_t    state;
	ctrl_pkg::db15_half_cnt_t half_cnt;
	ctrl_pkg::db15_bit_cnt_t  bit_cnt;
	ctrl_pkg::db15_frame_t    shift_reg;

	logic half_end;
	logic load_end;
	logic last_bit;

	// End of frame strobe, one cycle
	assign db15_valid = (state == ctrl_pkg::DONE);

	// Last cycle of a half period, of the load pulse, last pulse of the frame
	assign half_end = half_cnt
		== ctrl_pkg::db15_half_cnt_t'(ctrl_pkg::DB15_HALF_CYCLES - 1);
	assign load_end = half_cnt
		== ctrl_pkg::db15_half_cnt_t'(2 * ctrl_pkg::DB15_HALF_CYCLES - 1);
	assign last_bit = bit_cnt
		== ctrl_pkg::db15_bit_cnt_t'(ctrl_pkg::DB15_FRAME_BITS - 1);

	// ====================
	// Frame sequencer
	// ====================
	always_ff @(posedge clk_53p6) begin
		if (reset) begin
			state    <= ctrl_pkg::IDLE;
			half_cnt <= '0;
			bit_cnt  <= '0;
			joy_clk  <= 1'b0;
			joy_load <= 1'b0;
			db15_p1  <= ctrl_pkg::DB15_RELEASED;
			db15_p2  <= ctrl_pkg::DB15_RELEASED;
		end else begin
			case (state)
				ctrl_pkg::IDLE: begin
					// Start first load pulse
					joy_load <= 1'b1;
					half_cnt <= '0;
					state    <= ctrl_pkg::LOAD;
				end
				ctrl_pkg::LOAD: begin
					// Load held for two half periods
					if (load_end) begin
						joy_load <= 1'b0;
						half_cnt <= '0;
						bit_cnt  <= '0;
						state    <= ctrl_pkg::SHIFT;
					end else begin
						half_cnt <= half_cnt + 1'b1;
					end
				end
				ctrl_pkg::SHIFT: begin
					if (half_end) begin
						half_cnt <= '0;
						joy_clk  <= ~joy_clk;
						// Falling edge closes one pulse
						if (joy_clk) begin
							bit_cnt <= bit_cnt + 1'b1;
							if (last_bit) begin
								state <= ctrl_pkg::DONE;
							end
						end
					end else begin
						half_cnt <= half_cnt + 1'b1;
					end
				end
				ctrl_pkg::DONE: begin
					// Publish both players, then reload at once
					db15_p1  <= shift_reg[31:16];
					db15_p2  <= shift_reg[15:0];
					joy_load <= 1'b1;
					half_cnt <= '0;
					state    <= ctrl_pkg::LOAD;
				end
				default: begin
					state <= ctrl_pkg::IDLE;
				end
			endcase
		end
	end

	// ====================
	// Data shifter
	// ====================

	// Sample on the rising edge of joy_clk, MSB first
	always_ff @(posedge clk_53p6) begin
		if (state == ctrl_pkg::SHIFT && !joy_clk && half_end) begin
			shift_reg <= {shift_reg[30:0], joy_data};
		end
	end

endmodule

// File: logic/game_config.sv
// ====================
// DIP and game ID capture from the ROM download stream
// Only DIP bytes 0 and 1 are kept, others are dropped
// Menu mask lags the game ID by one cycle
// ====================
module game_config (
	input  logic                   clk_53p6,
	input  logic                   reset,
	input  logic                   ioctl_wr,
	input  ctrl_pkg::ioctl_index_t ioctl_index,
	input  ctrl_pkg::ioctl_addr_t  ioctl_addr,
	input  ctrl_pkg::dip_t         ioctl_dout,
	input  logic [1:0]             snac_sel,
	output ctrl_pkg::dip_t         dsw1,
	output ctrl_pkg::dip_t         dsw2,
	output ctrl_pkg::game_id_t     game,
	output ctrl_pkg::menu_mask_t   menu_mask,
	output logic [1:0]             db15_en
);

	logic dip_wr;
	logic game_wr;

	ctrl_pkg::menu_mask_t mask_next;

	// ====================
	// Download decode
	// ====================
	assign dip_wr  = ioctl_wr && (ioctl_index == ctrl_pkg::IDX_DIP);
	assign game_wr = ioctl_wr && (ioctl_index == ctrl_pkg::IDX_GAME)
		&& (ioctl_addr == '0);

	always_ff @(posedge clk_53p6) begin
		if (reset) begin
			dsw1 <= ctrl_pkg::DIP_DEFAULT;
			dsw2 <= ctrl_pkg::DIP_DEFAULT;
			game <= '0;
		end else begin
			// Byte 0 and byte 1 of the DIP block
			if (dip_wr && ioctl_addr == 25'd0) begin
				dsw1 <= ioctl_dout;
			end
			if (dip_wr && ioctl_addr == 25'd1) begin
				dsw2 <= ioctl_dout;
			end
			if (game_wr) begin
				game <= ioctl_dout;
			end
		end
	end

	// ====================
	// Game specific settings
	// ====================
	always_comb begin
		case (game)
			// Flip hack menu enabled
			ctrl_pkg::GAME_ATHENA:       mask_next = ctrl_pkg::MASK_DEFAULT & ~16'h0001;
			// Hide DB15 menu
			ctrl_pkg::GAME_COUNTRY_CLUB: mask_next = ctrl_pkg::MASK_DEFAULT | 16'h0002;
			default:                     mask_next = ctrl_pkg::MASK_DEFAULT;
		endcase
	end

	always_ff @(posedge clk_53p6) begin
		if (reset) begin
			menu_mask <= ctrl_pkg::MASK_DEFAULT;
		end else begin
			menu_mask <= mask_next;
		end
	end

	// Trackball game always uses USB
	assign db15_en = (game == ctrl_pkg::GAME_COUNTRY_CLUB) ? 2'b00 : snac_sel;

endmodule

// File: logic/player_mapper.sv
// ====================
// Maps USB or DB15 controls of one player onto the cabinet word
// Output word and pause are registered, one cycle latency
// DB15 Select+B gives service, Select+A gives pause
// ====================
module player_mapper (
	input  logic                   clk_53p6,
	input  logic                   reset,
	input  logic                   db15_en,
	input  ctrl_pkg::usb_joy_t     usb,
	input  ctrl_pkg::db15_word_t   db15,
	output ctrl_pkg::player_word_t player,
	output logic                   pause
);

	// Selected controls, all active low except pause
	logic up_n;
	logic down_n;
	logic right_n;
	logic left_n;
	logic service_n;
	logic btn1_n;
	logic btn2_n;
	logic start_n;
	logic coin_n;
	logic pause_req;

	ctrl_pkg::player_word_t player_next;

	// ====================
	// Source select
	// ====================
	always_comb begin
		if (db15_en) begin
			// DB15 bits already active low
			up_n      = db15[3];
			down_n    = db15[2];
			left_n    = db15[1];
			right_n   = db15[0];
			btn1_n    = db15[5];
			btn2_n    = db15[6];
			start_n   = db15[10];
			coin_n    = db15[11];
			// Select+B pressed together
			service_n = db15[5] | db15[11];
			// Select+A pressed together
			pause_req = ~(db15[4] | db15[11]);
		end else begin
			// USB is active high, invert
			up_n      = ~usb[3];
			down_n    = ~usb[2];
			left_n    = ~usb[1];
			right_n   = ~usb[0];
			btn1_n    = ~usb[4];
			btn2_n    = ~usb[5];
			start_n   = ~usb[6];
			coin_n    = ~usb[7];
			service_n = ~usb[8];
			pause_req = usb[9];
		end
	end

	// Cabinet layout, unused bits released
	assign player_next = {2'b11, up_n, down_n, right_n, left_n, service_n,
		5'b11111, btn2_n, btn1_n, start_n, coin_n};

	// ====================
	// Output registers
	// ====================
	always_ff @(posedge clk_53p6) begin
		if (reset) begin
			player <= ctrl_pkg::PLAYER_RELEASED;
			pause  <= 1'b0;
		end else begin
			player <= player_next;
			pause  <= pause_req;
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# Compile and run the testbench with Verilator, pass only on the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_top -f src.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "Testbench passed" &&
echo "PASS" || { echo "FAIL"; exit 1; }

// File: src.f
logic/ctrl_pkg.sv
logic/db15_reader.sv
logic/player_mapper.sv
logic/game_config.sv
logic/ctrl_top.sv
dv/tb_checker.sv
dv/tb_top.sv
